// File: hw/dot_data_pkg.sv
package dot_data_pkg;

    localparam int LANE_W = 32;                    // one x feature
    typedef logic signed [LANE_W-1:0] lane_t;

    // fraction bits kept below the lane lsb while shifting
    localparam int GUARD_BITS = 4;
    localparam int ACC_W      = LANE_W + GUARD_BITS;
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam acc_t ROUND_BIAS = acc_t'(11);      // loaded with the first plane of a sample

endpackage

// File: hw/dot_ctrl_pkg.sv
package dot_ctrl_pkg;

    localparam int CFG_W    = 32;                  // every config input
    localparam int BITS_MAX = 16;                  // deepest precision the shifter covers

    typedef logic [4:0]  bit_idx_t;
    typedef logic [11:0] chunk_t;
    typedef logic [9:0]  epoch_t;
    typedef logic [7:0]  credit_t;                 // wraps and only compared for inequality

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_EPOCH,
        ST_EPOCH_WAIT,                             // later epochs wait for x write-back
        ST_SAMPLE,
        ST_CHECK_X,                                // wait for an x credit
        ST_COMPUTE,
        ST_END
    } seq_state_t;

endpackage

// File: hw/dot_config_regs.sv
`timescale 1ns/1ps

module dot_config_regs #(
    parameter int LANES = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic                           x_written_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0] num_epochs_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0] num_samples_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0] dimension_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0] num_bits_i,
    output logic                           start_o,
    output logic                           x_written_o,
    output dot_ctrl_pkg::epoch_t           num_epochs_o,
    output logic [dot_ctrl_pkg::CFG_W-1:0] num_samples_o,
    output dot_ctrl_pkg::chunk_t           last_chunk_o,
    output dot_ctrl_pkg::bit_idx_t         last_bit_o
);

    localparam int CW        = dot_ctrl_pkg::CFG_W;
    localparam int LANE_BITS = $clog2(LANES);

    logic [CW-1:0] chunk_cnt;                      // dimension over LANES rounded up

    assign chunk_cnt = (dimension_i >> LANE_BITS) + CW'(|dimension_i[LANE_BITS-1:0]);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start_o     <= 1'b0;
            x_written_o <= 1'b0;
        end
        else
        begin
            start_o     <= start_i;                // one sync stage
            x_written_o <= x_written_i;
        end
    end

    // loop limits taken while start is up and held afterwards
    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            num_epochs_o  <= dot_ctrl_pkg::epoch_t'(num_epochs_i);
            num_samples_o <= num_samples_i;
            last_chunk_o  <= dot_ctrl_pkg::chunk_t'(chunk_cnt - 1'b1);
            last_bit_o    <= dot_ctrl_pkg::bit_idx_t'(num_bits_i - 1'b1);
        end
    end

    // precision beyond BITS_MAX would fall off the shifter
    a_num_bits: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (num_bits_i >= 1) && (num_bits_i <= dot_ctrl_pkg::BITS_MAX));

endmodule

// File: hw/plane_fifo.sv
`timescale 1ns/1ps

module plane_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_BITS = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en_i,
    input  logic [WIDTH-1:0]    wr_data_i,
    input  logic                rd_en_i,
    output logic [WIDTH-1:0]    rd_data_o,
    output logic                rd_valid_o,
    output logic                empty_o,
    output logic [DEPTH_BITS:0] count_o,
    output logic                almost_full_o
);

    localparam int DEPTH = 1 << DEPTH_BITS;
    localparam int CNT_W = DEPTH_BITS + 1;

    logic [WIDTH-1:0]      mem [DEPTH];            // lut ram with async read
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic [CNT_W-1:0]      count_nxt;

    assign empty_o   = (count_o == '0);
    assign count_nxt = count_o + CNT_W'(wr_en_i) - CNT_W'(rd_en_i);

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
            mem[wr_ptr] <= wr_data_i;
        if (rd_en_i)
            rd_data_o <= mem[rd_ptr];              // registered read port
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count_o       <= '0;
            rd_valid_o    <= 1'b0;
            almost_full_o <= 1'b0;
        end
        else
        begin
            if (wr_en_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en_i)
                rd_ptr <= rd_ptr + 1'b1;
            count_o       <= count_nxt;
            rd_valid_o    <= rd_en_i;              // data lands one cycle after the strobe
            // four slots of slack for the writer
            almost_full_o <= (count_nxt >= CNT_W'(DEPTH - 4));
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> (count_o != CNT_W'(DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en_i |-> !empty_o);

endmodule

// File: hw/sample_sequencer.sv
`timescale 1ns/1ps

module sample_sequencer #(
    parameter int BANKS           = 4,
    parameter int FIFO_DEPTH_BITS = 5,
    parameter int X_ADDR_BITS     = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic                           x_written_i,
    input  dot_ctrl_pkg::epoch_t           num_epochs_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0] num_samples_i,
    input  dot_ctrl_pkg::chunk_t           last_chunk_i,
    input  dot_ctrl_pkg::bit_idx_t         last_bit_i,
    input  dot_ctrl_pkg::credit_t          x_wr_credit_i,
    input  logic                           fifo_empty_i,
    input  logic [FIFO_DEPTH_BITS:0]       fifo_count_i,
    output logic                           fifo_rd_en_o,
    output logic                           x_rd_en_o,
    output logic [X_ADDR_BITS-1:0]         x_rd_addr_o,
    output logic                           done_o
);

    localparam int CW    = dot_ctrl_pkg::CFG_W;
    localparam int CNT_W = FIFO_DEPTH_BITS + 1;

    dot_ctrl_pkg::seq_state_t state;
    dot_ctrl_pkg::epoch_t     epoch_idx;          // epochs entered so far
    logic [CW-1:0]            sample_idx;         // first sample of the next group
    dot_ctrl_pkg::chunk_t     chunk_idx;
    dot_ctrl_pkg::bit_idx_t   bit_idx;
    dot_ctrl_pkg::credit_t    rd_credit;          // groups started
    logic                     rd_safe;

    // last word already claimed by the read in flight
    assign rd_safe = !(fifo_empty_i || ((fifo_count_i == CNT_W'(1)) && fifo_rd_en_o));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= dot_ctrl_pkg::ST_IDLE;
            epoch_idx    <= '0;
            sample_idx   <= '0;
            chunk_idx    <= '0;
            bit_idx      <= '0;
            rd_credit    <= '0;
            fifo_rd_en_o <= 1'b0;
            x_rd_en_o    <= 1'b0;
            done_o       <= 1'b0;
        end
        else
        begin
            fifo_rd_en_o <= 1'b0;                  // strobes
            x_rd_en_o    <= 1'b0;
            case (state)
                dot_ctrl_pkg::ST_IDLE:
                begin
                    if (start_i)
                        state <= dot_ctrl_pkg::ST_START;
                end
                dot_ctrl_pkg::ST_START:
                begin
                    epoch_idx <= '0;
                    rd_credit <= '0;
                    state     <= dot_ctrl_pkg::ST_EPOCH;
                end
                dot_ctrl_pkg::ST_EPOCH:
                begin
                    sample_idx <= '0;
                    epoch_idx  <= epoch_idx + 1'b1;
                    if (epoch_idx == num_epochs_i)
                        state <= dot_ctrl_pkg::ST_END;
                    else
                        state <= dot_ctrl_pkg::ST_EPOCH_WAIT;
                end
                dot_ctrl_pkg::ST_EPOCH_WAIT:
                begin
                    // epoch 1 runs on the initial x
                    if ((epoch_idx == 10'd1) || x_written_i)
                        state <= dot_ctrl_pkg::ST_SAMPLE;
                end
                dot_ctrl_pkg::ST_SAMPLE:
                begin
                    chunk_idx <= '0;
                    bit_idx   <= '0;
                    if (sample_idx == num_samples_i)
                        state <= dot_ctrl_pkg::ST_EPOCH;
                    else
                    begin
                        sample_idx <= sample_idx + CW'(BANKS);   // one sample per bank
                        state      <= dot_ctrl_pkg::ST_CHECK_X;
                    end
                end
                dot_ctrl_pkg::ST_CHECK_X:
                begin
                    if (x_wr_credit_i != rd_credit)
                    begin
                        rd_credit <= rd_credit + 1'b1;   // consume one credit
                        state     <= dot_ctrl_pkg::ST_COMPUTE;
                    end
                end
                dot_ctrl_pkg::ST_COMPUTE:
                begin
                    if (rd_safe)
                    begin
                        fifo_rd_en_o <= 1'b1;
                        if (bit_idx == '0)
                        begin
                            x_rd_en_o   <= 1'b1;         // fresh chunk needs its x word
                            x_rd_addr_o <= chunk_idx[X_ADDR_BITS-1:0];
                        end
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_bit_i)
                        begin
                            bit_idx   <= '0;
                            chunk_idx <= chunk_idx + 1'b1;
                            if (chunk_idx == last_chunk_i)
                                state <= dot_ctrl_pkg::ST_SAMPLE;
                        end
                    end
                end
                dot_ctrl_pkg::ST_END:
                    done_o <= 1'b1;                // stays until reset
                default:
                    state <= dot_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    // the read-ahead guess must never drain the fifo
    a_rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd_en_o |-> !fifo_empty_i);

endmodule

// File: hw/bank_adder_tree.sv
`timescale 1ns/1ps

module bank_adder_tree #(
    parameter int LANES = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  dot_data_pkg::lane_t lanes_i [LANES],
    input  logic [LANES-1:0]    mask_i,
    input  logic                valid_i,
    output dot_data_pkg::lane_t sum_o,
    output logic                valid_o
);

    localparam int LEVELS = $clog2(LANES) + 1;     // masked leaves plus adder levels

    // heap layout with node n fed by 2n+1 and 2n+2
    dot_data_pkg::lane_t node [2*LANES-1];
    logic [LEVELS-1:0]   valid_q;

    always_ff @(posedge clk)
    begin
        for (int j = 0; j < LANES; j++)
            node[LANES-1+j] <= mask_i[j] ? lanes_i[j] : '0;   // lanes with a zero bit drop out
        for (int n = 0; n < LANES-1; n++)
            node[n] <= node[2*n+1] + node[2*n+2];             // wraps at lane width
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid_q <= '0;
        else
            valid_q <= {valid_q[LEVELS-2:0], valid_i};        // one bit per tree level
    end

    assign sum_o   = node[0];
    assign valid_o = valid_q[LEVELS-1];

endmodule

// File: hw/bit_serial_accumulator.sv
`timescale 1ns/1ps

module bit_serial_accumulator #(
    parameter int BANKS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dot_data_pkg::lane_t    sums_i [BANKS],
    input  logic                   valid_i,
    input  dot_ctrl_pkg::chunk_t   last_chunk_i,
    input  dot_ctrl_pkg::bit_idx_t last_bit_i,
    output dot_data_pkg::lane_t    dot_o [BANKS],
    output logic                   dot_valid_o
);

    localparam int GB = dot_data_pkg::GUARD_BITS;
    localparam int LW = dot_data_pkg::LANE_W;
    localparam int AW = dot_data_pkg::ACC_W;

    dot_ctrl_pkg::bit_idx_t bit_idx;               // plane position shared by all banks
    dot_ctrl_pkg::chunk_t   chunk_idx;
    dot_data_pkg::acc_t     shifted [BANKS];
    dot_data_pkg::acc_t     acc [BANKS];
    logic                   sh_valid;
    logic                   sh_first;              // first plane of a sample
    logic                   sh_last;               // last plane of the last chunk
    logic                   acc_done;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bit_idx     <= '0;
            chunk_idx   <= '0;
            sh_valid    <= 1'b0;
            sh_first    <= 1'b0;
            sh_last     <= 1'b0;
            acc_done    <= 1'b0;
            dot_valid_o <= 1'b0;
        end
        else
        begin
            sh_valid    <= valid_i;
            sh_first    <= valid_i && (bit_idx == '0) && (chunk_idx == '0);
            sh_last     <= valid_i && (bit_idx == last_bit_i) && (chunk_idx == last_chunk_i);
            acc_done    <= sh_last;
            dot_valid_o <= acc_done;
            if (valid_i)
            begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == last_bit_i)
                begin
                    bit_idx   <= '0;
                    chunk_idx <= (chunk_idx == last_chunk_i) ? '0 : chunk_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < BANKS; i++)
        begin
            // weight 2^-(b+1) with guard bits below the lane
            shifted[i] <= dot_data_pkg::acc_t'({sums_i[i], GB'(0)}) >>> (bit_idx + 1'b1);
            if (sh_valid)
                acc[i] <= sh_first ? shifted[i] + dot_data_pkg::ROUND_BIAS : acc[i] + shifted[i];
            if (acc_done)
                dot_o[i] <= acc[i][AW-1 -: LW];    // drop the guard bits
        end
    end

endmodule

// File: hw/dot_product_top.sv
`timescale 1ns/1ps

module dot_product_top #(
    parameter int BANKS           = 4,
    parameter int LANES           = 8,
    parameter int FIFO_DEPTH_BITS = 5,
    parameter int X_ADDR_BITS     = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0]        num_epochs_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0]        num_samples_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0]        dimension_i,
    input  logic [dot_ctrl_pkg::CFG_W-1:0]        num_bits_i,
    input  logic [BANKS*LANES-1:0]                a_data_i,
    input  logic                                  a_wr_en_i,
    output logic                                  a_almost_full_o,
    input  dot_ctrl_pkg::credit_t                 x_wr_credit_i,
    input  logic                                  x_written_i,
    output logic                                  x_rd_en_o,
    output logic [X_ADDR_BITS-1:0]                x_rd_addr_o,
    input  logic [LANES*dot_data_pkg::LANE_W-1:0] x_rd_data_i,
    output dot_data_pkg::lane_t                   dot_o [BANKS],
    output logic                                  dot_valid_o,
    output logic                                  done_o
);

    localparam int PLANE_W = BANKS * LANES;
    localparam int LW      = dot_data_pkg::LANE_W;

    logic                           start_s;
    logic                           x_written_s;
    dot_ctrl_pkg::epoch_t           num_epochs;
    logic [dot_ctrl_pkg::CFG_W-1:0] num_samples;
    dot_ctrl_pkg::chunk_t           last_chunk;
    dot_ctrl_pkg::bit_idx_t         last_bit;
    logic                           fifo_rd_en;
    logic [PLANE_W-1:0]             fifo_rd_data;
    logic                           fifo_rd_valid;
    logic                           fifo_empty;
    logic [FIFO_DEPTH_BITS:0]       fifo_count;
    logic [PLANE_W-1:0]             plane_q;       // plane word feeding the trees
    logic                           plane_vld_q;
    logic                           x_rd_en_d;     // x memory answers now
    logic [LANES*LW-1:0]            x_word_q;      // held across every plane of a chunk
    dot_data_pkg::lane_t            x_lanes [LANES];
    dot_data_pkg::lane_t            tree_sum [BANKS];
    logic [BANKS-1:0]               tree_valid;

    dot_config_regs #(.LANES(LANES)) i_dot_config_regs (
        .clk, .rst_n, .start_i, .x_written_i,
        .num_epochs_i, .num_samples_i, .dimension_i, .num_bits_i,
        .start_o       (start_s),
        .x_written_o   (x_written_s),
        .num_epochs_o  (num_epochs),
        .num_samples_o (num_samples),
        .last_chunk_o  (last_chunk),
        .last_bit_o    (last_bit)
    );

    plane_fifo #(.WIDTH(PLANE_W), .DEPTH_BITS(FIFO_DEPTH_BITS)) i_plane_fifo (
        .clk, .rst_n,
        .wr_en_i       (a_wr_en_i),
        .wr_data_i     (a_data_i),
        .rd_en_i       (fifo_rd_en),
        .rd_data_o     (fifo_rd_data),
        .rd_valid_o    (fifo_rd_valid),
        .empty_o       (fifo_empty),
        .count_o       (fifo_count),
        .almost_full_o (a_almost_full_o)
    );

    sample_sequencer #(
        .BANKS(BANKS), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS), .X_ADDR_BITS(X_ADDR_BITS)
    ) i_sample_sequencer (
        .clk, .rst_n,
        .start_i       (start_s),
        .x_written_i   (x_written_s),
        .num_epochs_i  (num_epochs),
        .num_samples_i (num_samples),
        .last_chunk_i  (last_chunk),
        .last_bit_i    (last_bit),
        .x_wr_credit_i,
        .fifo_empty_i  (fifo_empty),
        .fifo_count_i  (fifo_count),
        .fifo_rd_en_o  (fifo_rd_en),
        .x_rd_en_o, .x_rd_addr_o, .done_o
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            plane_vld_q <= 1'b0;
            x_rd_en_d   <= 1'b0;
        end
        else
        begin
            plane_vld_q <= fifo_rd_valid;
            x_rd_en_d   <= x_rd_en_o;
        end
    end

    // plane and x word line up here
    always_ff @(posedge clk)
    begin
        plane_q <= fifo_rd_data;
        if (x_rd_en_d)
            x_word_q <= x_rd_data_i;
    end

    for (genvar j = 0; j < LANES; j++)
    begin : g_x_lane
        assign x_lanes[j] = x_word_q[j*LW +: LW];
    end

    for (genvar b = 0; b < BANKS; b++)
    begin : g_bank
        bank_adder_tree #(.LANES(LANES)) i_bank_adder_tree (
            .clk, .rst_n,
            .lanes_i (x_lanes),
            .mask_i  (plane_q[b*LANES +: LANES]),   // this bank's a bits
            .valid_i (plane_vld_q),
            .sum_o   (tree_sum[b]),
            .valid_o (tree_valid[b])
        );
    end

    bit_serial_accumulator #(.BANKS(BANKS)) i_bit_serial_accumulator (
        .clk, .rst_n,
        .sums_i       (tree_sum),
        .valid_i      (&tree_valid),               // banks run in lockstep
        .last_chunk_i (last_chunk),
        .last_bit_i   (last_bit),
        .dot_o, .dot_valid_o
    );

endmodule

// File: dv/dot_product_tb.sv
`timescale 1ns/1ps

module dot_product_tb;

    localparam int BANKS       = 4;
    localparam int LANES       = 8;
    localparam int PLANE_W     = BANKS * LANES;   // 32 with the default top
    localparam int X_WORDS     = 64;              // 6 address bits
    localparam int FIFO_DEPTH  = 32;              // 5 depth bits
    localparam int HOLD_CYCLES = 100;             // credit held back this long
    localparam int GATE_CYCLES = 30;              // epoch 2 kept waiting on x_written
    localparam int CASE_MARGIN = 600;             // reset, prefill, holds and drain
    localparam int NCASES      = 5;

    typedef struct packed {
        logic [31:0] epochs;
        logic [31:0] samples;                     // multiple of BANKS
        logic [31:0] dim;
        logic [31:0] bits;
        logic        credit_hold;                 // x credit kept at zero for a while
        logic        bp;                          // fifo filled before start
    } case_t;

    localparam case_t CASE_TABLE [NCASES] = '{
        '{32'd1, 32'd8,  32'd8,  32'd1,  1'b0, 1'b0},
        '{32'd3, 32'd8,  32'd20, 32'd16, 1'b0, 1'b0},   // last chunk half used
        '{32'd2, 32'd8,  32'd16, 32'd3,  1'b1, 1'b0},
        '{32'd2, 32'd16, 32'd24, 32'd8,  1'b0, 1'b1},
        '{32'd0, 32'd4,  32'd8,  32'd2,  1'b0, 1'b0}
    };

    string case_names [NCASES] = '{"single chunk and bit", "chunks, bits and epochs",
                                   "credit gating", "back-pressure", "zero epochs"};

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       start_i;
    logic [31:0]                num_epochs_i;
    logic [31:0]                num_samples_i;
    logic [31:0]                dimension_i;
    logic [31:0]                num_bits_i;
    logic [PLANE_W-1:0]         a_data_i;
    logic                       a_wr_en_i;
    logic                       a_almost_full_o;
    dot_ctrl_pkg::credit_t      x_wr_credit_i;
    logic                       x_written_i;
    logic                       x_rd_en_o;
    logic [5:0]                 x_rd_addr_o;
    logic [LANES*32-1:0]        x_rd_data_i;
    dot_data_pkg::lane_t        dot_o [BANKS];
    logic                       dot_valid_o;
    logic                       done_o;

    logic [LANES*32-1:0]        xmem [X_WORDS];   // host side x memory
    logic [PLANE_W-1:0]         planes [$];       // write order = read order
    logic [31:0]                exp_q [$];        // BANKS entries per group
    logic [31:0]                exp_v;
    logic                       x_pend;
    logic [5:0]                 x_pend_addr;
    logic                       prefill_done;
    logic                       af_seen;
    int                         errors = 0;
    int                         res_cnt = 0;
    int                         total_pulses = 0;

    dot_product_top i_dot_product_top (
        .clk, .rst_n, .start_i,
        .num_epochs_i, .num_samples_i, .dimension_i, .num_bits_i,
        .a_data_i, .a_wr_en_i, .a_almost_full_o,
        .x_wr_credit_i, .x_written_i,
        .x_rd_en_o, .x_rd_addr_o, .x_rd_data_i,
        .dot_o, .dot_valid_o, .done_o
    );

    always #2 clk = ~clk;                         // 4 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // x memory answers one cycle after the read strobe
    always @(negedge clk)
    begin
        x_pend      = x_rd_en_o;
        x_pend_addr = x_rd_addr_o;
    end

    always @(posedge clk)
    begin
        #1;
        if (x_pend)
            x_rd_data_i = xmem[x_pend_addr];
    end

    // result monitor checks every bank at each pulse
    always @(negedge clk)
    begin
        if (rst_n && dot_valid_o)
        begin
            if (exp_q.size() < BANKS)
            begin
                $display("unexpected dot_valid_o pulse at %0t with no result pending", $time);
                errors++;
            end
            else
            begin
                for (int b = 0; b < BANKS; b++)
                begin
                    exp_v = exp_q.pop_front();
                    check_value($sformatf("dot_o[%0d]", b), dot_o[b], exp_v);
                end
            end
            res_cnt++;
        end
    end

    function automatic longint watchdog_cycles();
        longint total;
        int     chunks;
        total = 0;
        for (int c = 0; c < NCASES; c++)
        begin
            chunks = (CASE_TABLE[c].dim + LANES - 1) / LANES;
            total += CASE_TABLE[c].epochs * (CASE_TABLE[c].samples / BANKS) * chunks
                     * CASE_TABLE[c].bits * 20;   // 20 cycles per plane
            total += CASE_MARGIN;
        end
        return total;
    endfunction

    initial
    begin
        longint budget;
        budget = watchdog_cycles();
        repeat (budget) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("Finished with errors");
        $finish;
    end

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        a_wr_en_i     = 1'b0;
        x_written_i   = 1'b0;
        x_wr_credit_i = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // random x, random planes and the expected dot products
    task automatic build_case(input int c);
        int                 chunks;
        int                 groups;
        int                 v;
        logic [PLANE_W-1:0] plane;
        logic signed [31:0] s;
        logic signed [35:0] term;
        logic signed [35:0] acc [BANKS];
        chunks = (CASE_TABLE[c].dim + LANES - 1) / LANES;
        groups = CASE_TABLE[c].samples / BANKS;
        planes.delete();
        exp_q.delete();
        for (int w = 0; w < X_WORDS; w++)
        begin
            for (int j = 0; j < LANES; j++)
            begin
                v = int'($urandom % 2097152) - 1048576;   // 21 bit signed so no sum wraps
                xmem[w][j*32 +: 32] = (w * LANES + j < CASE_TABLE[c].dim) ? v : 0;
            end
        end
        for (int e = 0; e < CASE_TABLE[c].epochs; e++)
        begin
            for (int g = 0; g < groups; g++)
            begin
                for (int b = 0; b < BANKS; b++)
                    acc[b] = 36'sd11;             // rounding bias once per sample
                for (int k = 0; k < chunks; k++)
                begin
                    for (int t = 0; t < CASE_TABLE[c].bits; t++)
                    begin
                        plane = PLANE_W'($urandom);
                        planes.push_back(plane);
                        for (int b = 0; b < BANKS; b++)
                        begin
                            s = '0;
                            for (int j = 0; j < LANES; j++)
                                if (plane[b*LANES + j])
                                    s = s + $signed(xmem[k][j*32 +: 32]);
                            term   = 36'(s) * 36'sd16;   // 4 fraction bits
                            term   = term >>> (t + 1);   // weight 2^-(t+1)
                            acc[b] = acc[b] + term;
                        end
                    end
                end
                for (int b = 0; b < BANKS; b++)
                    exp_q.push_back(acc[b][35:4]);
            end
        end
    endtask

    task automatic write_planes(input logic bp);
        int idx;
        idx = 0;
        if (!bp)
            prefill_done = 1'b1;
        while (idx < planes.size())
        begin
            @(posedge clk);
            #1;
            if (a_almost_full_o)
            begin
                // nothing read yet, so every written plane is still held
                if (bp && !af_seen)
                    check_value("planes written at a_almost_full_o", idx, FIFO_DEPTH - 4);
                af_seen      = 1'b1;
                prefill_done = 1'b1;
            end
            if (!a_almost_full_o && (bp || (($urandom % 4) != 0)))
            begin
                a_wr_en_i = 1'b1;
                a_data_i  = planes[idx];
                idx++;
            end
            else
                a_wr_en_i = 1'b0;
        end
        @(posedge clk);
        #1;
        a_wr_en_i    = 1'b0;
        prefill_done = 1'b1;                      // short runs never fill up
    endtask

    task automatic drive_control(input int c, input int groups);
        int total;
        total = CASE_TABLE[c].epochs * groups;
        wait (prefill_done);
        @(posedge clk);
        #1;
        x_wr_credit_i = CASE_TABLE[c].credit_hold ? '0 : dot_ctrl_pkg::credit_t'(total);
        start_i       = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        if (CASE_TABLE[c].credit_hold)
        begin
            repeat (HOLD_CYCLES)
            begin
                @(negedge clk);
                check_value("x_rd_en_o", x_rd_en_o, 0);
                check_value("dot_valid_o", dot_valid_o, 0);
            end
            @(posedge clk);
            #1;
            x_wr_credit_i = dot_ctrl_pkg::credit_t'(total);
        end
        if (CASE_TABLE[c].epochs > 1)
        begin
            while (res_cnt < groups)
                @(negedge clk);                   // epoch 1 fully out
            repeat (GATE_CYCLES)
            begin
                @(negedge clk);
                check_value("x_rd_en_o", x_rd_en_o, 0);
            end
            @(posedge clk);
            #1;
            x_written_i = 1'b1;                   // stays up for later epochs
        end
    endtask

    task automatic run_case(input int c);
        int groups;
        int exp_res;
        int err_before;
        int wait_cnt;
        err_before = errors;
        groups     = CASE_TABLE[c].samples / BANKS;
        exp_res    = CASE_TABLE[c].epochs * groups;
        build_case(c);
        apply_reset();
        num_epochs_i  = CASE_TABLE[c].epochs;
        num_samples_i = CASE_TABLE[c].samples;
        dimension_i   = CASE_TABLE[c].dim;
        num_bits_i    = CASE_TABLE[c].bits;
        res_cnt       = 0;
        prefill_done  = 1'b0;
        af_seen       = 1'b0;
        fork
            write_planes(CASE_TABLE[c].bp);
            drive_control(c, groups);
        join
        while (!done_o)
            @(negedge clk);
        wait_cnt = 0;
        while ((res_cnt < exp_res) && (wait_cnt < 64))
        begin
            @(negedge clk);                       // done can beat the last result
            wait_cnt++;
        end
        repeat (8) @(negedge clk);
        check_value("result count", res_cnt, exp_res);
        if (CASE_TABLE[c].bp)
            check_value("a_almost_full_o seen", af_seen, 1);
        total_pulses += res_cnt;
        $display("test %0d %s: %0d results, %0d errors", c + 1, case_names[c], res_cnt,
                 errors - err_before);
    endtask

    initial
    begin
        rst_n         = 1'b0;
        start_i       = 1'b0;
        num_epochs_i  = '0;
        num_samples_i = '0;
        dimension_i   = '0;
        num_bits_i    = 32'd1;
        a_data_i      = '0;
        a_wr_en_i     = 1'b0;
        x_wr_credit_i = '0;
        x_written_i   = 1'b0;
        x_rd_data_i   = '0;
        void'($urandom(64703));
        apply_reset();
        @(negedge clk);
        check_value("done_o", done_o, 0);
        check_value("dot_valid_o", dot_valid_o, 0);
        check_value("x_rd_en_o", x_rd_en_o, 0);
        check_value("a_almost_full_o", a_almost_full_o, 0);
        $display("test 0 reset state: %0d errors", errors);
        for (int c = 0; c < NCASES; c++)
            run_case(c);
        $display("tests %0d, result pulses %0d, errors %0d", NCASES + 1, total_pulses, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: build.f
hw/dot_data_pkg.sv
hw/dot_ctrl_pkg.sv
hw/dot_config_regs.sv
hw/plane_fifo.sv
hw/sample_sequencer.sv
hw/bank_adder_tree.sv
hw/bit_serial_accumulator.sv
hw/dot_product_top.sv
dv/dot_product_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module dot_product_tb -o dot_product_sim -f build.f

./obj_dir/dot_product_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
